//--- rtl/regop_config.svh
/*
  Design-wide sizes for the register-operation core.
  REGOP_AW must cover REGOP_NUM_REGS, and REGOP_LOCKSTEP_DELAY must be 1 or more.
*/

`ifndef REGOP_CONFIG_SVH
`define REGOP_CONFIG_SVH

// Register file geometry
`define REGOP_NUM_REGS 32
`define REGOP_AW 5

// Datapath width
`define REGOP_DW 32

// Cycles the shadow core trails the main core
`define REGOP_LOCKSTEP_DELAY 2

`endif

//--- rtl/regop_pkg.sv
/*
  Shared types for the core, register file and lockstep checker.
  Field widths follow the macros in the config header.
*/

`include "regop_config.svh"

package regop_pkg;

  typedef logic [`REGOP_AW-1:0] addr_t;
  typedef logic [`REGOP_DW-1:0] data_t;

  typedef enum logic [1:0] {
    OP_LI   = 2'd0,
    OP_ADD  = 2'd1,
    OP_XOR  = 2'd2,
    OP_ADDI = 2'd3
  } regop_e;

  // One command as sampled at the top level
  typedef struct packed {
    logic   valid;
    regop_e op;
    addr_t  rd;
    addr_t  rs1;
    addr_t  rs2;
    data_t  imm;
  } cmd_t;

  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t data;
  } rf_wr_t;

  typedef struct packed {
    data_t a;
    data_t b;
  } rf_rd_t;

  typedef struct packed {
    addr_t a;
    addr_t b;
  } rf_ra_t;

endpackage

//--- rtl/regop_rf_if.sv
/*
  Operand read and write-back bundle between a core and its register file.
  Reads are combinational, the write lands at the next clock edge.
*/

`include "regop_config.svh"

interface regop_rf_if;

  logic [`REGOP_AW-1:0] raddr_a;
  logic [`REGOP_AW-1:0] raddr_b;
  logic [`REGOP_DW-1:0] rdata_a;
  logic [`REGOP_DW-1:0] rdata_b;
  logic                 we;
  logic [`REGOP_AW-1:0] waddr;
  logic [`REGOP_DW-1:0] wdata;

  modport core (
    output raddr_a, raddr_b, we, waddr, wdata,
    input  rdata_a, rdata_b
  );

  modport rf (
    input  raddr_a, raddr_b, we, waddr, wdata,
    output rdata_a, rdata_b
  );

endinterface

//--- rtl/regop_delay_line.sv
/*
  Fixed-latency shift register, REGOP_LOCKSTEP_DELAY stages deep.
  All stages reset to zero. The payload type must be a packed type.
*/

`include "regop_config.svh"

module regop_delay_line #(
  parameter type payload_t = regop_pkg::cmd_t
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t data_i,
  output payload_t data_o
);

  localparam int unsigned Depth = `REGOP_LOCKSTEP_DELAY;

  payload_t stages_q [Depth];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Depth; i++) begin
        stages_q[i] <= '0;
      end
    end else begin
      stages_q[0] <= data_i;
      for (int i = 1; i < Depth; i++) begin
        stages_q[i] <= stages_q[i-1];
      end
    end
  end

  // Oldest stage
  assign data_o = stages_q[Depth-1];

endmodule

//--- rtl/regop_core.sv
/*
  Single execute stage: a command sampled at one edge writes back at the next.
  No back-pressure, so a command is accepted every cycle that valid is high.
  Register 0 is never written.
*/

module regop_core (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  regop_pkg::cmd_t cmd_i,
  regop_rf_if.core        rf,
  output logic            busy_o,
  output logic            sleep_o
);

  import regop_pkg::*;

  cmd_t  cmd_q;
  data_t result;

  ////////////////////////////////////////////////////////////////////////////
  // Execute stage register
  ////////////////////////////////////////////////////////////////////////////

  // Payload only moves on a valid command so idle cycles keep it stable
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_q <= '0;
    end else begin
      cmd_q.valid <= cmd_i.valid;
      if (cmd_i.valid) begin
        cmd_q.op  <= cmd_i.op;
        cmd_q.rd  <= cmd_i.rd;
        cmd_q.rs1 <= cmd_i.rs1;
        cmd_q.rs2 <= cmd_i.rs2;
        cmd_q.imm <= cmd_i.imm;
      end
    end
  end

  // Operand read
  assign rf.raddr_a = cmd_q.rs1;
  assign rf.raddr_b = cmd_q.rs2;

  ////////////////////////////////////////////////////////////////////////////
  // ALU and write-back
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (cmd_q.op)
      OP_LI:   result = cmd_q.imm;
      OP_ADD:  result = rf.rdata_a + rf.rdata_b;
      OP_XOR:  result = rf.rdata_a ^ rf.rdata_b;
      OP_ADDI: result = rf.rdata_a + cmd_q.imm;
      default: result = '0;
    endcase
  end

  assign rf.we    = cmd_q.valid && (cmd_q.rd != '0);
  assign rf.waddr = cmd_q.rd;
  assign rf.wdata = result;

  // Status
  assign busy_o  = cmd_q.valid;
  assign sleep_o = ~cmd_q.valid & ~cmd_i.valid;

  // Operands and immediate must be resolved whenever a write is issued
  write_data_known_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rf.we |-> !$isunknown(rf.wdata)
  ) else $error("register write with unknown data");

endmodule

//--- rtl/regop_reg_file.sv
/*
  Flop-based register file, all registers reset to zero.
  Register 0 is a constant zero and ignores writes.
  Operand and observation reads are combinational.
*/

`include "regop_config.svh"

module regop_reg_file (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  regop_rf_if.rf               rf,
  input  logic [`REGOP_AW-1:0] obs_addr_i,
  output logic [`REGOP_DW-1:0] obs_data_o
);

  import regop_pkg::*;

  data_t regs [`REGOP_NUM_REGS];

  for (genvar i = 0; i < `REGOP_NUM_REGS; i++) begin : gen_regs
    if (i == 0) begin : gen_zero
      assign regs[i] = '0;
    end else begin : gen_flop
      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          regs[i] <= '0;
        end else if (rf.we && (rf.waddr == addr_t'(i))) begin
          regs[i] <= rf.wdata;
        end
      end
    end
  end

  // Read ports
  assign rf.rdata_a = regs[rf.raddr_a];
  assign rf.rdata_b = regs[rf.raddr_b];
  assign obs_data_o = regs[obs_addr_i];

  // Core side must present a clean address with any write
  waddr_known_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rf.we |-> !$isunknown(rf.waddr)
  ) else $error("register write with unknown address");

endmodule

//--- rtl/regop_lockstep.sv
/*
  Shadow core running REGOP_LOCKSTEP_DELAY cycles behind the main core.
  The shadow core has no register file of its own and uses delayed main read data.
  Any difference in read addresses or writes sets a major alert that holds until reset.
*/

module regop_lockstep (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  regop_pkg::cmd_t   cmd_i,
  input  regop_pkg::rf_ra_t main_ra_i,
  input  regop_pkg::rf_rd_t main_rd_i,
  input  regop_pkg::rf_wr_t main_wr_i,
  output logic              alert_major_o
);

  import regop_pkg::*;

  cmd_t   cmd_d;
  rf_ra_t ra_d;
  rf_rd_t rd_d;
  rf_wr_t wr_d;
  rf_ra_t shadow_ra;
  rf_wr_t shadow_wr;
  logic   mismatch;
  logic   alert_q;

  ////////////////////////////////////////////////////////////////////////////
  // Delayed copies of the main core's traffic
  ////////////////////////////////////////////////////////////////////////////

  regop_delay_line #(.payload_t(cmd_t)) u_delay_cmd (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (cmd_i),
    .data_o (cmd_d)
  );

  regop_delay_line #(.payload_t(rf_ra_t)) u_delay_ra (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (main_ra_i),
    .data_o (ra_d)
  );

  regop_delay_line #(.payload_t(rf_rd_t)) u_delay_rd (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (main_rd_i),
    .data_o (rd_d)
  );

  regop_delay_line #(.payload_t(rf_wr_t)) u_delay_wr (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (main_wr_i),
    .data_o (wr_d)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Shadow core
  ////////////////////////////////////////////////////////////////////////////

  regop_rf_if shadow_rf ();

  regop_core u_shadow_core (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cmd_i   (cmd_d),
    .rf      (shadow_rf.core),
    .busy_o  (),
    .sleep_o ()
  );

  // Operands come from the main register file, replayed
  assign shadow_rf.rdata_a = rd_d.a;
  assign shadow_rf.rdata_b = rd_d.b;

  // Compare and hold
  assign shadow_ra = '{a: shadow_rf.raddr_a, b: shadow_rf.raddr_b};
  assign shadow_wr = '{we: shadow_rf.we, addr: shadow_rf.waddr, data: shadow_rf.wdata};
  assign mismatch  = (shadow_ra != ra_d) || (shadow_wr != wr_d);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= alert_q | mismatch;
    end
  end

  assign alert_major_o = alert_q;

  alert_known_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(alert_major_o)
  ) else $error("lockstep alert is unknown");

endmodule

//--- rtl/regop_top.sv
/*
  Top level: main core, register file and lockstep checker.
  Commands are a one-cycle valid strobe with no back-pressure.
  core_sleep_o only reports the idle condition, no clock is gated.
*/

`include "regop_config.svh"

module regop_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 cmd_valid_i,
  input  regop_pkg::regop_e    cmd_op_i,
  input  logic [`REGOP_AW-1:0] cmd_rd_i,
  input  logic [`REGOP_AW-1:0] cmd_rs1_i,
  input  logic [`REGOP_AW-1:0] cmd_rs2_i,
  input  logic [`REGOP_DW-1:0] cmd_imm_i,
  input  logic [`REGOP_AW-1:0] obs_addr_i,
  output logic [`REGOP_DW-1:0] obs_data_o,
  output logic                 alert_major_o,
  output logic                 core_sleep_o
);

  import regop_pkg::*;

  cmd_t   cmd;
  rf_ra_t main_ra;
  rf_rd_t main_rd;
  rf_wr_t main_wr;

  regop_rf_if core_rf ();

  assign cmd = '{
    valid: cmd_valid_i,
    op:    cmd_op_i,
    rd:    cmd_rd_i,
    rs1:   cmd_rs1_i,
    rs2:   cmd_rs2_i,
    imm:   cmd_imm_i
  };

  ////////////////////////////////////////////////////////////////////////////
  // Main core and register file
  ////////////////////////////////////////////////////////////////////////////

  regop_core u_core (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cmd_i   (cmd),
    .rf      (core_rf.core),
    .busy_o  (),
    .sleep_o (core_sleep_o)
  );

  regop_reg_file u_reg_file (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rf         (core_rf.rf),
    .obs_addr_i (obs_addr_i),
    .obs_data_o (obs_data_o)
  );

  // Main core traffic as seen by the checker
  assign main_ra = '{a: core_rf.raddr_a, b: core_rf.raddr_b};
  assign main_rd = '{a: core_rf.rdata_a, b: core_rf.rdata_b};
  assign main_wr = '{we: core_rf.we, addr: core_rf.waddr, data: core_rf.wdata};

  regop_lockstep u_lockstep (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_i         (cmd),
    .main_ra_i     (main_ra),
    .main_rd_i     (main_rd),
    .main_wr_i     (main_wr),
    .alert_major_o (alert_major_o)
  );

endmodule

//--- tests/regop_tb.sv
/*
  Directed tests for the register-operation core with its lockstep checker.
  A reference register array mirrors every issued command in issue order.
  Inputs change on the falling clock edge, outputs are sampled just after it.
*/

`include "regop_config.svh"

module regop_tb;

  import regop_pkg::*;

  localparam int ClkPeriod = 8;
  localparam int NumRandom = 200;
  localparam int NumRegs = `REGOP_NUM_REGS;
  // Two full register sweeps per test plus the directed commands
  localparam int DirectedCycles = 8 * NumRegs;
  localparam int MarginCycles = 100;
  localparam int TimeoutCycles = NumRandom + DirectedCycles + MarginCycles;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 cmd_valid_i;
  regop_e               cmd_op_i;
  logic [`REGOP_AW-1:0] cmd_rd_i;
  logic [`REGOP_AW-1:0] cmd_rs1_i;
  logic [`REGOP_AW-1:0] cmd_rs2_i;
  logic [`REGOP_DW-1:0] cmd_imm_i;
  logic [`REGOP_AW-1:0] obs_addr_i;
  logic [`REGOP_DW-1:0] obs_data_o;
  logic                 alert_major_o;
  logic                 core_sleep_o;

  logic [31:0] model_regs [NumRegs];
  logic [31:0] rng_state = 32'hcd9c;
  int          error_count = 0;
  int          check_count = 0;
  logic        alert_seen = 1'b0;

  regop_top uut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_op_i      (cmd_op_i),
    .cmd_rd_i      (cmd_rd_i),
    .cmd_rs1_i     (cmd_rs1_i),
    .cmd_rs2_i     (cmd_rs2_i),
    .cmd_imm_i     (cmd_imm_i),
    .obs_addr_i    (obs_addr_i),
    .obs_data_o    (obs_data_o),
    .alert_major_o (alert_major_o),
    .core_sleep_o  (core_sleep_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  // Alert must never rise in a fault-free run
  always @(negedge clk_i) begin
    if (rst_ni && alert_major_o !== 1'b0) begin
      alert_seen = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Issue one command and apply it to the reference registers
  task automatic drive_cmd(input regop_e op, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [31:0] imm);
    logic [31:0] result;
    @(negedge clk_i);
    cmd_valid_i = 1'b1;
    cmd_op_i    = op;
    cmd_rd_i    = rd;
    cmd_rs1_i   = rs1;
    cmd_rs2_i   = rs2;
    cmd_imm_i   = imm;
    case (op)
      OP_LI:   result = imm;
      OP_ADD:  result = model_regs[rs1] + model_regs[rs2];
      OP_XOR:  result = model_regs[rs1] ^ model_regs[rs2];
      default: result = model_regs[rs1] + imm;
    endcase
    if (rd != 5'd0) begin
      model_regs[rd] = result;
    end
  endtask

  task automatic end_stream();
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  task automatic check_reg(input string name, input int addr);
    @(negedge clk_i);
    obs_addr_i = addr[4:0];
    #1;
    check_value($sformatf("%s r%0d", name, addr), model_regs[addr], obs_data_o);
  endtask

  task automatic check_all_regs(input string name);
    for (int i = 0; i < NumRegs; i++) begin
      check_reg(name, i);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    check_value("reset sleep", 32'd1, {31'd0, core_sleep_o});
    check_value("reset alert", 32'd0, {31'd0, alert_major_o});
    check_all_regs("reset");
  endtask

  task automatic test_load_imm();
    logic [31:0] values [4];
    values = '{32'h1234_5678, 32'hffff_ffff, 32'h0000_0001, 32'h8000_0000};
    for (int i = 0; i < 4; i++) begin
      drive_cmd(OP_LI, 5'(3 * i + 1), 5'd0, 5'd0, values[i]);
      end_stream();
      check_reg("load_imm", 3 * i + 1);
    end
  endtask

  task automatic test_alu_ops();
    drive_cmd(OP_LI, 5'd1, 5'd0, 5'd0, 32'hffff_fff0);
    drive_cmd(OP_LI, 5'd2, 5'd0, 5'd0, 32'h0000_0025);
    drive_cmd(OP_ADD, 5'd3, 5'd1, 5'd2, 32'd0);
    drive_cmd(OP_XOR, 5'd4, 5'd3, 5'd1, 32'd0);
    drive_cmd(OP_ADDI, 5'd5, 5'd4, 5'd0, 32'hffff_ff00);
    drive_cmd(OP_ADD, 5'd3, 5'd5, 5'd3, 32'd0);
    end_stream();
    for (int i = 1; i <= 5; i++) begin
      check_reg("alu_ops", i);
    end
  endtask

  task automatic test_reg_zero();
    drive_cmd(OP_LI, 5'd0, 5'd0, 5'd0, 32'hdead_beef);
    drive_cmd(OP_ADDI, 5'd0, 5'd1, 5'd0, 32'd5);
    drive_cmd(OP_ADD, 5'd6, 5'd0, 5'd2, 32'd0);
    drive_cmd(OP_XOR, 5'd7, 5'd0, 5'd0, 32'd0);
    drive_cmd(OP_ADDI, 5'd8, 5'd0, 5'd0, 32'h0bad_f00d);
    end_stream();
    check_reg("reg_zero", 0);
    for (int i = 6; i <= 8; i++) begin
      check_reg("reg_zero", i);
    end
  endtask

  task automatic test_random_stream();
    logic [31:0] r1;
    logic [31:0] r2;
    for (int n = 0; n < NumRandom; n++) begin
      rng_state = xorshift32(rng_state);
      r1 = rng_state;
      rng_state = xorshift32(rng_state);
      r2 = rng_state;
      drive_cmd(regop_e'(r1[1:0]), r1[6:2], r1[11:7], r1[16:12], r2);
      #1;
      check_value($sformatf("random_stream sleep cmd %0d", n), 32'd0, {31'd0, core_sleep_o});
    end
    end_stream();
    check_all_regs("random_stream");
    check_value("random_stream sleep after", 32'd1, {31'd0, core_sleep_o});
    check_value("random_stream alert", 32'd0, {31'd0, alert_seen});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni      = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_op_i    = OP_LI;
    cmd_rd_i    = '0;
    cmd_rs1_i   = '0;
    cmd_rs2_i   = '0;
    cmd_imm_i   = '0;
    obs_addr_i  = '0;
    for (int i = 0; i < NumRegs; i++) begin
      model_regs[i] = 32'd0;
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;

    test_reset();
    test_load_imm();
    test_alu_ops();
    test_reg_zero();
    test_random_stream();

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- regop_top.f
+incdir+rtl
rtl/regop_pkg.sv
rtl/regop_rf_if.sv
rtl/regop_delay_line.sv
rtl/regop_core.sv
rtl/regop_reg_file.sv
rtl/regop_lockstep.sv
rtl/regop_top.sv
tests/regop_tb.sv

//--- Bender.yml
package:
  name: regop

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/regop_pkg.sv
      - rtl/regop_rf_if.sv
      - rtl/regop_delay_line.sv
      - rtl/regop_core.sv
      - rtl/regop_reg_file.sv
      - rtl/regop_lockstep.sv
      - rtl/regop_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/regop_tb.sv
